// File: filelist.f
+incdir+hw
hw/cache_pkg.sv
hw/l1_cache.sv
hw/memory_arbiter.sv
hw/backing_ram.sv
hw/caches_top.sv
tb/caches_top_assert.sv
tb/tb_caches_top.sv

// File: hw/backing_ram.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module backing_ram
  import cache_pkg::*;
(
  input  wire        CLK,
  input  wire        i_rst_n,
  input  wire        i_cyc,
  input  wire        i_stb,
  input  wire        i_we,
  input  wire addr_t i_adr,
  input  wire word_t i_dat,
  output word_t      o_dat,
  output logic       o_ack
);

  word_t mem [`RAM_DEPTH];
  word_t dat_q;
  logic  ack_q;
  logic  take; // new strobe, not the one being acked

  assign take = i_cyc & i_stb & ~ack_q;

  // known pattern so reads of unwritten words can be predicted
  initial begin
    for (int a = 0; a < `RAM_DEPTH; a++) begin
      mem[a] = word_t'(a) ^ `RAM_INIT_KEY;
    end
  end

  always @(posedge CLK) begin
    if (take && i_we) mem[i_adr] <= i_dat;
    if (take) dat_q <= i_we ? i_dat : mem[i_adr]; // write echoes its data
  end

  always_ff @(posedge CLK or negedge i_rst_n) begin
    if (!i_rst_n) ack_q <= 1'b0;
    else          ack_q <= take; // single ack, one cycle later
  end

  assign o_ack = ack_q;
  assign o_dat = dat_q;

endmodule

`default_nettype wire

// File: hw/cache_pkg.sv
`default_nettype none

`include "cache_settings.svh"

package cache_pkg;

  // address split for a direct-mapped, one-word-per-line cache
  localparam int INDEX_W = $clog2(`NUM_LINES);
  localparam int TAG_W   = `ADDR_W - INDEX_W;

  typedef logic [31:0]         word_t;  // bus data word
  typedef logic [`ADDR_W-1:0]  addr_t;  // word address
  typedef logic [INDEX_W-1:0]  index_t; // line select, low addr bits
  typedef logic [TAG_W-1:0]    tag_t;   // rest of the address

  // one cache line
  typedef struct packed {
    logic  valid;
    tag_t  tag;
    word_t data;
  } line_t;

endpackage

`default_nettype wire

// File: hw/cache_settings.svh
`ifndef CACHE_SETTINGS_SVH
`define CACHE_SETTINGS_SVH

// word address width, shared by every bus
`define ADDR_W 12

// lines per l1, one word each
`define NUM_LINES 16

// upper quarter of the map is io space
`define NONCACHE_START_ADDR 12'hC00

// one ram word per word address
`define RAM_DEPTH (1 << `ADDR_W)

// ram word a starts as a ^ key
`define RAM_INIT_KEY 32'h5A3C_96E1

`endif

// File: hw/caches_top.sv
`timescale 1ns/1ps
`default_nettype none

module caches_top
  import cache_pkg::*;
(
  input  wire        CLK,
  input  wire        i_rst_n,
  input  wire        i_iclear,
  output logic       o_iclear_done,
  input  wire        i_dclear,
  output logic       o_dclear_done,
  // instruction port
  input  wire        i_icpu_cyc,
  input  wire        i_icpu_stb,
  input  wire        i_icpu_we,   // tied low by the core
  input  wire addr_t i_icpu_adr,
  input  wire word_t i_icpu_dat,
  output word_t      o_icpu_dat,
  output logic       o_icpu_ack,
  // data port
  input  wire        i_dcpu_cyc,
  input  wire        i_dcpu_stb,
  input  wire        i_dcpu_we,
  input  wire addr_t i_dcpu_adr,
  input  wire word_t i_dcpu_dat,
  output word_t      o_dcpu_dat,
  output logic       o_dcpu_ack
);

  // icache to arbiter
  logic  imem_cyc, imem_stb, imem_we, imem_ack;
  addr_t imem_adr;
  word_t imem_dat_w, imem_dat_r;
  // dcache to arbiter
  logic  dmem_cyc, dmem_stb, dmem_we, dmem_ack;
  addr_t dmem_adr;
  word_t dmem_dat_w, dmem_dat_r;
  // arbiter to ram
  logic  mem_cyc, mem_stb, mem_we, mem_ack;
  addr_t mem_adr;
  word_t mem_dat_w, mem_dat_r;

  l1_cache u_icache (
    .CLK(CLK), .i_rst_n(i_rst_n), .i_clear(i_iclear), .o_clear_done(o_iclear_done),
    .i_cpu_cyc(i_icpu_cyc), .i_cpu_stb(i_icpu_stb), .i_cpu_we(i_icpu_we),
    .i_cpu_adr(i_icpu_adr), .i_cpu_dat(i_icpu_dat),
    .o_cpu_dat(o_icpu_dat), .o_cpu_ack(o_icpu_ack),
    .o_mem_cyc(imem_cyc), .o_mem_stb(imem_stb), .o_mem_we(imem_we),
    .o_mem_adr(imem_adr), .o_mem_dat(imem_dat_w),
    .i_mem_dat(imem_dat_r), .i_mem_ack(imem_ack)
  );

  l1_cache u_dcache (
    .CLK(CLK), .i_rst_n(i_rst_n), .i_clear(i_dclear), .o_clear_done(o_dclear_done),
    .i_cpu_cyc(i_dcpu_cyc), .i_cpu_stb(i_dcpu_stb), .i_cpu_we(i_dcpu_we),
    .i_cpu_adr(i_dcpu_adr), .i_cpu_dat(i_dcpu_dat),
    .o_cpu_dat(o_dcpu_dat), .o_cpu_ack(o_dcpu_ack),
    .o_mem_cyc(dmem_cyc), .o_mem_stb(dmem_stb), .o_mem_we(dmem_we),
    .o_mem_adr(dmem_adr), .o_mem_dat(dmem_dat_w),
    .i_mem_dat(dmem_dat_r), .i_mem_ack(dmem_ack)
  );

  memory_arbiter u_arb (
    .CLK(CLK), .i_rst_n(i_rst_n),
    .i_im_cyc(imem_cyc), .i_im_stb(imem_stb), .i_im_we(imem_we),
    .i_im_adr(imem_adr), .i_im_dat(imem_dat_w), .o_im_dat(imem_dat_r), .o_im_ack(imem_ack),
    .i_dm_cyc(dmem_cyc), .i_dm_stb(dmem_stb), .i_dm_we(dmem_we),
    .i_dm_adr(dmem_adr), .i_dm_dat(dmem_dat_w), .o_dm_dat(dmem_dat_r), .o_dm_ack(dmem_ack),
    .o_mem_cyc(mem_cyc), .o_mem_stb(mem_stb), .o_mem_we(mem_we),
    .o_mem_adr(mem_adr), .o_mem_dat(mem_dat_w),
    .i_mem_dat(mem_dat_r), .i_mem_ack(mem_ack)
  );

  backing_ram u_ram (
    .CLK(CLK), .i_rst_n(i_rst_n),
    .i_cyc(mem_cyc), .i_stb(mem_stb), .i_we(mem_we),
    .i_adr(mem_adr), .i_dat(mem_dat_w), .o_dat(mem_dat_r), .o_ack(mem_ack)
  );

endmodule

`default_nettype wire

// File: hw/l1_cache.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module l1_cache
  import cache_pkg::*;
(
  input  wire        CLK,
  input  wire        i_rst_n,
  input  wire        i_clear,      // invalidate all lines
  output logic       o_clear_done, // one-cycle pulse at the end of a clear
  // cpu side, wishbone slave
  input  wire        i_cpu_cyc,
  input  wire        i_cpu_stb,
  input  wire        i_cpu_we,
  input  wire addr_t i_cpu_adr,
  input  wire word_t i_cpu_dat,
  output word_t      o_cpu_dat,
  output logic       o_cpu_ack,
  // memory side, wishbone master
  output logic       o_mem_cyc,
  output logic       o_mem_stb,
  output logic       o_mem_we,
  output addr_t      o_mem_adr,
  output word_t      o_mem_dat,
  input  wire word_t i_mem_dat,
  input  wire        i_mem_ack
);

  typedef enum logic [2:0] {
    S_IDLE,   // wait for cpu request or clear
    S_LOOKUP, // tag compare on the latched address
    S_MEM,    // one downstream transfer
    S_RESP,   // ack the cpu after memory
    S_CLEAR   // walk all lines
  } state_e;

  state_e state_q;
  line_t  lines [`NUM_LINES];

  addr_t  req_adr_q;    // latched request
  word_t  req_dat_q;
  logic   req_we_q;
  word_t  rdata_q;      // word returned by memory
  index_t clr_idx_q;    // line being invalidated
  logic   clear_q;      // i_clear last cycle, for edge detect
  logic   clear_pend_q; // clear seen while busy
  logic   clear_done_q;

  index_t req_idx;
  tag_t   req_tag;
  line_t  cur_line;
  logic   noncache;
  logic   hit;
  logic   rd_hit;
  logic   cpu_req;
  logic   clear_rise;

  assign req_idx    = req_adr_q[INDEX_W-1:0];
  assign req_tag    = req_adr_q[`ADDR_W-1:INDEX_W];
  assign cur_line   = lines[req_idx];
  assign noncache   = (req_adr_q >= `NONCACHE_START_ADDR); // io space never cached
  assign hit        = ~noncache & cur_line.valid & (cur_line.tag == req_tag);
  assign rd_hit     = hit & ~req_we_q;
  assign cpu_req    = i_cpu_cyc & i_cpu_stb;
  assign clear_rise = i_clear & ~clear_q;

  // control and line state
  always_ff @(posedge CLK or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state_q      <= S_IDLE;
      clr_idx_q    <= '0;
      clear_q      <= 1'b0;
      clear_pend_q <= 1'b0;
      clear_done_q <= 1'b0;
      for (int i = 0; i < `NUM_LINES; i++) begin
        lines[i] <= '0; // all lines invalid out of reset
      end
    end else begin
      clear_q      <= i_clear;
      clear_done_q <= 1'b0;
      if (clear_rise) clear_pend_q <= 1'b1; // remember until idle

      case (state_q)
        S_IDLE: begin
          if (clear_pend_q || clear_rise) begin // clear beats a cpu request
            clear_pend_q <= 1'b0;
            clr_idx_q    <= '0;
            state_q      <= S_CLEAR;
          end else if (cpu_req) begin
            state_q <= S_LOOKUP;
          end
        end
        S_LOOKUP: begin
          state_q <= rd_hit ? S_IDLE : S_MEM; // read hit acks right here
        end
        S_MEM: begin
          if (i_mem_ack) begin
            state_q <= S_RESP;
            if (!req_we_q && !noncache) begin
              // read miss fill
              lines[req_idx] <= '{valid: 1'b1, tag: req_tag, data: i_mem_dat};
            end else if (req_we_q && hit) begin
              lines[req_idx].data <= req_dat_q; // write hit, no allocate on miss
            end
          end
        end
        S_RESP: begin
          state_q <= S_IDLE;
        end
        S_CLEAR: begin
          lines[clr_idx_q].valid <= 1'b0;
          clr_idx_q <= clr_idx_q + 1'b1;
          if (clr_idx_q == index_t'(`NUM_LINES - 1)) begin
            clear_done_q <= 1'b1; // last line done
            state_q      <= S_IDLE;
          end
        end
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // request and response payload
  always_ff @(posedge CLK) begin
    if (state_q == S_IDLE && cpu_req) begin
      req_adr_q <= i_cpu_adr;
      req_dat_q <= i_cpu_dat;
      req_we_q  <= i_cpu_we;
    end
    if (state_q == S_MEM && i_mem_ack) rdata_q <= i_mem_dat;
  end

  assign o_cpu_ack = (state_q == S_LOOKUP && rd_hit) || (state_q == S_RESP);
  assign o_cpu_dat = (state_q == S_LOOKUP) ? cur_line.data : rdata_q;

  // downstream request held for the whole memory state
  assign o_mem_cyc = (state_q == S_MEM);
  assign o_mem_stb = (state_q == S_MEM);
  assign o_mem_we  = (state_q == S_MEM) & req_we_q;
  assign o_mem_adr = req_adr_q;
  assign o_mem_dat = req_dat_q;

  assign o_clear_done = clear_done_q;

endmodule

`default_nettype wire

// File: hw/memory_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module memory_arbiter
  import cache_pkg::*;
(
  input  wire        CLK,
  input  wire        i_rst_n,
  // icache master
  input  wire        i_im_cyc,
  input  wire        i_im_stb,
  input  wire        i_im_we,
  input  wire addr_t i_im_adr,
  input  wire word_t i_im_dat,
  output word_t      o_im_dat,
  output logic       o_im_ack,
  // dcache master
  input  wire        i_dm_cyc,
  input  wire        i_dm_stb,
  input  wire        i_dm_we,
  input  wire addr_t i_dm_adr,
  input  wire word_t i_dm_dat,
  output word_t      o_dm_dat,
  output logic       o_dm_ack,
  // shared memory bus
  output logic       o_mem_cyc,
  output logic       o_mem_stb,
  output logic       o_mem_we,
  output addr_t      o_mem_adr,
  output word_t      o_mem_dat,
  input  wire word_t i_mem_dat,
  input  wire        i_mem_ack
);

  logic owner_q; // 0 icache, 1 dcache
  logic last_q;  // last master that finished a transfer
  logic grant;

  // owner keeps the bus while it holds cyc
  always_comb begin
    if (owner_q ? i_dm_cyc : i_im_cyc) grant = owner_q;
    else                               grant = i_dm_cyc; // otherwise whoever asks
  end

  always_ff @(posedge CLK or negedge i_rst_n) begin
    if (!i_rst_n) begin
      owner_q <= 1'b0;
      last_q  <= 1'b1; // icache wins the first tie
    end else begin
      owner_q <= o_mem_cyc ? grant : ~last_q; // idle bus parks on the other master
      if (i_mem_ack) last_q <= grant;
    end
  end

  // request mux, no pipeline stage
  assign o_mem_cyc = grant ? i_dm_cyc : i_im_cyc;
  assign o_mem_stb = grant ? i_dm_stb : i_im_stb;
  assign o_mem_we  = grant ? i_dm_we  : i_im_we;
  assign o_mem_adr = grant ? i_dm_adr : i_im_adr;
  assign o_mem_dat = grant ? i_dm_dat : i_im_dat;

  // response only to the granted master
  assign o_im_ack = ~grant & i_mem_ack;
  assign o_dm_ack = grant & i_mem_ack;
  assign o_im_dat = grant ? '0 : i_mem_dat;
  assign o_dm_dat = grant ? i_mem_dat : '0;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# build the cache testbench with verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f filelist.f --top-module tb_caches_top \
  -o sim_tb || { echo "build failed"; exit 1; }

# error limit raised so assertion failures reach the final report
./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1
cat sim.log

grep -qx "TEST PASS" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

// File: tb/caches_top_assert.sv
`timescale 1ns/1ps
`default_nettype none

module caches_top_assert
  import cache_pkg::*;
(
  input wire        CLK,
  input wire        i_rst_n,
  input wire        i_icpu_stb,
  input wire        o_icpu_ack,
  input wire        i_dcpu_stb,
  input wire        o_dcpu_ack,
  input wire        imem_cyc,
  input wire        imem_stb,
  input wire        imem_we,
  input wire        imem_ack,
  input wire addr_t imem_adr,
  input wire        dmem_cyc,
  input wire        dmem_stb,
  input wire        dmem_we,
  input wire        dmem_ack,
  input wire addr_t dmem_adr,
  input wire        mem_cyc,
  input wire        mem_stb,
  input wire        mem_we,
  input wire        mem_ack,
  input wire addr_t mem_adr
);

  int fail_count = 0; // read by the testbench at the end

  // an ack only ever answers a live strobe
  ack_needs_stb: assert property (@(posedge CLK) disable iff (!i_rst_n)
      (!o_icpu_ack || i_icpu_stb) && (!o_dcpu_ack || i_dcpu_stb) && (!mem_ack || mem_stb))
    else begin
      fail_count++;
      $error("ack seen without stb");
    end

  // pending request frozen until acked
  imem_hold: assert property (@(posedge CLK) disable iff (!i_rst_n)
      (imem_stb && !imem_ack) |=> (imem_stb && $stable(imem_adr) && $stable(imem_we)))
    else begin
      fail_count++;
      $error("imem request changed before ack");
    end

  dmem_hold: assert property (@(posedge CLK) disable iff (!i_rst_n)
      (dmem_stb && !dmem_ack) |=> (dmem_stb && $stable(dmem_adr) && $stable(dmem_we)))
    else begin
      fail_count++;
      $error("dmem request changed before ack");
    end

  mem_hold: assert property (@(posedge CLK) disable iff (!i_rst_n)
      (mem_stb && !mem_ack) |=> (mem_stb && $stable(mem_adr) && $stable(mem_we)))
    else begin
      fail_count++;
      $error("mem request changed before ack");
    end

  // quiet buses right out of reset
  reset_idle: assert property (@(posedge CLK) $rose(i_rst_n) |->
      !(imem_cyc || imem_stb || dmem_cyc || dmem_stb || mem_cyc || mem_stb ||
        o_icpu_ack || o_dcpu_ack))
    else begin
      fail_count++;
      $error("bus active after reset");
    end

endmodule

bind caches_top caches_top_assert u_assert (.*);

`default_nettype wire

// File: tb/tb_caches_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "cache_settings.svh"

module tb_caches_top
  import cache_pkg::*;
();

  localparam int ACK_TIMEOUT   = 200; // cycles, covers waiting on the arbiter
  localparam int CLEAR_TIMEOUT = 100;
  localparam int NUM_RAND      = 40;

  logic  CLK;
  logic  i_rst_n;
  logic  i_iclear, i_dclear;
  logic  o_iclear_done, o_dclear_done;
  logic  i_icpu_cyc, i_icpu_stb, i_icpu_we;
  addr_t i_icpu_adr;
  word_t i_icpu_dat, o_icpu_dat;
  logic  o_icpu_ack;
  logic  i_dcpu_cyc, i_dcpu_stb, i_dcpu_we;
  addr_t i_dcpu_adr;
  word_t i_dcpu_dat, o_dcpu_dat;
  logic  o_dcpu_ack;

  word_t  sb [`RAM_DEPTH]; // mirror of ram contents
  int     value_errs;
  int     timeout_errs;
  int     assert_errs;
  integer seed;

  caches_top i_caches_top (.*);

  always #4 CLK = ~CLK; // 8 ns period

  task automatic check_word(input string sig, input addr_t adr, input word_t got,
                            input word_t exp);
    if (got !== exp) begin
      value_errs++;
      $display("error: %s at adr %h got %h expected %h", sig, adr, got, exp);
    end
  endtask

  task automatic check_done(input string sig, input logic got);
    if (got !== 1'b1) begin
      value_errs++;
      $display("error: %s got %h expected %h", sig, got, 1'b1);
    end
  endtask

  // one classic cycle on a cpu port, inputs change on the falling edge
  task automatic bus_transfer(input bit dport, input logic we, input addr_t adr,
                              input word_t wdat, output word_t rdat);
    int   cycles;
    logic ack;
    cycles = 0;
    ack    = 1'b0;
    @(negedge CLK);
    if (dport) begin
      {i_dcpu_cyc, i_dcpu_stb, i_dcpu_we} = {2'b11, we};
      {i_dcpu_adr, i_dcpu_dat}            = {adr, wdat};
    end else begin
      {i_icpu_cyc, i_icpu_stb, i_icpu_we, i_icpu_adr} = {3'b110, adr}; // no ifetch writes
    end
    while (!ack && cycles < ACK_TIMEOUT) begin
      @(negedge CLK);
      cycles++;
      ack = dport ? o_dcpu_ack : o_icpu_ack;
    end
    rdat = dport ? o_dcpu_dat : o_icpu_dat; // valid with ack
    if (ack) @(negedge CLK); // stb stays up over the edge that samples ack
    if (dport) {i_dcpu_cyc, i_dcpu_stb, i_dcpu_we} = 3'b000;
    else       {i_icpu_cyc, i_icpu_stb} = 2'b00;
    if (!ack) begin
      timeout_errs++;
      $display("timeout: %s port got no ack for address %h", dport ? "dcpu" : "icpu", adr);
    end
  endtask

  task automatic wb_read(input bit dport, input addr_t adr, output word_t rdat);
    bus_transfer(dport, 1'b0, adr, '0, rdat);
  endtask

  task automatic wb_write(input bit dport, input addr_t adr, input word_t wdat);
    word_t unused;
    bus_transfer(dport, 1'b1, adr, wdat, unused);
    sb[adr] = wdat; // write-through, ram now holds it
  endtask

  task automatic read_expect(input bit dport, input addr_t adr, input word_t exp);
    word_t got;
    wb_read(dport, adr, got);
    check_word(dport ? "o_dcpu_dat" : "o_icpu_dat", adr, got, exp);
  endtask

  task automatic do_clear(input bit dport);
    int   cycles;
    logic done;
    cycles = 0;
    done   = 1'b0;
    @(negedge CLK);
    if (dport) i_dclear = 1'b1;
    else       i_iclear = 1'b1;
    @(negedge CLK);
    i_iclear = 1'b0;
    i_dclear = 1'b0;
    while (!done && cycles < CLEAR_TIMEOUT) begin
      @(negedge CLK);
      cycles++;
      done = dport ? o_dclear_done : o_iclear_done;
    end
    check_done(dport ? "o_dclear_done" : "o_iclear_done", done);
  endtask

  task automatic fill_and_hit();
    addr_t a;
    a = 12'h123;
    read_expect(1'b1, a, word_t'(a) ^ `RAM_INIT_KEY); // miss, line filled
    read_expect(1'b1, a, word_t'(a) ^ `RAM_INIT_KEY); // hit
  endtask

  task automatic write_through();
    wb_write(1'b1, 12'h123, 32'hCAFE_0123); // write hit
    read_expect(1'b1, 12'h123, 32'hCAFE_0123);
    wb_write(1'b1, 12'h2B7, 32'h0BAD_F00D); // write miss, no allocate
    read_expect(1'b1, 12'h2B7, 32'h0BAD_F00D);
    read_expect(1'b0, 12'h123, 32'hCAFE_0123); // icache never fetched these
    read_expect(1'b0, 12'h2B7, 32'h0BAD_F00D);
  endtask

  // icache is not snooped, so a dcpu write leaves its copy stale
  task automatic stale_check(input addr_t a, input word_t nv, input bit noncache);
    word_t old;
    old = sb[a];
    read_expect(1'b0, a, old);
    wb_write(1'b1, a, nv);
    if (noncache) begin
      read_expect(1'b0, a, nv); // io space goes straight to ram
    end else begin
      read_expect(1'b0, a, old);
      do_clear(1'b0);
      read_expect(1'b0, a, nv);
    end
  endtask

  task automatic concurrent_traffic();
    addr_t ia  [NUM_RAND];
    addr_t da  [NUM_RAND];
    logic  dwe [NUM_RAND];
    word_t dd  [NUM_RAND];
    word_t rnd;
    // stimulus fixed up front so both ports see the same sequence every run
    for (int n = 0; n < NUM_RAND; n++) begin
      rnd    = $random(seed);
      ia[n]  = {4'h4, 3'b000, rnd[4:0]};  // icpu 0x400..0x41f
      da[n]  = {4'h8, 3'b000, rnd[12:8]}; // dcpu 0x800..0x81f, index conflicts
      dwe[n] = rnd[16];
      dd[n]  = $random(seed);
    end
    fork
      for (int n = 0; n < NUM_RAND; n++) read_expect(1'b0, ia[n], sb[ia[n]]);
      for (int n = 0; n < NUM_RAND; n++) begin
        if (dwe[n]) wb_write(1'b1, da[n], dd[n]);
        else        read_expect(1'b1, da[n], sb[da[n]]);
      end
    join
  endtask

  initial begin
    CLK          = 1'b0;
    i_rst_n      = 1'b0;
    seed         = 93042;
    value_errs   = 0;
    timeout_errs = 0;
    i_iclear     = 1'b0;
    i_dclear     = 1'b0;
    {i_icpu_cyc, i_icpu_stb, i_icpu_we, i_icpu_adr, i_icpu_dat} = '0;
    {i_dcpu_cyc, i_dcpu_stb, i_dcpu_we, i_dcpu_adr, i_dcpu_dat} = '0;
    for (int a = 0; a < `RAM_DEPTH; a++) begin
      sb[a] = word_t'(a) ^ `RAM_INIT_KEY; // ram power-up pattern
    end
    repeat (10) @(posedge CLK);
    @(negedge CLK);
    i_rst_n = 1'b1;

    fill_and_hit();
    write_through();
    stale_check(12'h345, 32'h1357_9BDF, 1'b0);
    stale_check(12'hC21, 32'h2468_ACE0, 1'b1);
    do_clear(1'b1);
    read_expect(1'b1, 12'h123, sb[12'h123]); // refetch after dcache clear
    concurrent_traffic();

    repeat (4) @(negedge CLK);
    assert_errs = i_caches_top.u_assert.fail_count;
    $display("errors: value %0d, timeout %0d, assertion %0d",
             value_errs, timeout_errs, assert_errs);
    if (value_errs + timeout_errs + assert_errs == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
